// File: hw/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  parameter int unsigned NrSbEntries = 4;
  parameter int unsigned WriteBackPorts = 2;

  typedef logic [1:0] sb_tag_t;

  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_BU
  } fu_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    CF_JAL,
    CF_JALR
  } bu_op_e;

  // The fu field of the instruction selects which view is meaningful.
  typedef union packed {
    alu_op_e alu;
    bu_op_e  bu;
  } fu_op_u;

  typedef struct packed {
    logic [31:0] pc;
    fu_e         fu;
    fu_op_u      op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic        is_rv16;
  } decoder_t;

  typedef struct packed {
    sb_tag_t     tag;
    fu_op_u      op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        is_rv16;
  } fu_data_t;

  typedef struct packed {
    logic        valid;
    sb_tag_t     tag;
    logic [31:0] data;
  } writeback_t;

  typedef struct packed {
    logic [NrSbEntries-1:0]       finished;
    logic [NrSbEntries-1:0][31:0] result;
  } forwarding_t;

  // Newest in-flight writer of one architectural register.
  typedef struct packed {
    logic    pending;
    sb_tag_t tag;
  } reg_pending_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        is_branch;
    logic        taken;
    logic [31:0] dnpc;
  } retire_t;

endpackage

`default_nettype wire

// File: hw/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
  import ooo_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       alu_valid,
  input  fu_data_t   fu_data,
  output writeback_t wb_alu
);

  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] result;
  logic        valid_q;
  sb_tag_t     tag_q;
  logic [31:0] data_q;

  assign a = fu_data.operand_a;
  assign b = fu_data.operand_b;

  always_comb begin
    case (fu_data.op.alu)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << b[4:0];
      ALU_SRL: result = a >> b[4:0];
      ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= alu_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (alu_valid) begin
      tag_q <= fu_data.tag;
      data_q <= result;
    end
  end

  assign wb_alu = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit
  import ooo_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  logic        bu_valid,
  input  fu_data_t    fu_data,
  output logic        bu_ready,
  output writeback_t  wb_bu,
  output logic        branch_taken,
  output logic [31:0] branch_address
);

  logic [31:0] a;
  logic [31:0] b;
  logic        is_jump;
  logic        taken;
  logic [31:0] target;
  logic [31:0] next_pc;
  logic        s1_valid_q;
  sb_tag_t     s1_tag_q;
  logic        s1_jump_q;
  logic        s1_taken_q;
  logic [31:0] s1_address_q;
  logic [31:0] s1_next_pc_q;
  logic        s2_valid_q;
  sb_tag_t     s2_tag_q;
  logic [31:0] s2_link_q;

  assign a = fu_data.operand_a;
  assign b = fu_data.operand_b;
  assign is_jump = fu_data.op.bu inside {CF_JAL, CF_JALR};
  assign next_pc = fu_data.pc + (fu_data.is_rv16 ? 32'd2 : 32'd4);

  always_comb begin
    case (fu_data.op.bu)
      BR_EQ:   taken = (a == b);
      BR_NE:   taken = (a != b);
      BR_LT:   taken = $signed(a) < $signed(b);
      BR_GE:   taken = $signed(a) >= $signed(b);
      BR_LTU:  taken = a < b;
      BR_GEU:  taken = a >= b;
      default: taken = 1'b1;
    endcase
  end

  // JALR jumps register relative with bit 0 forced low.
  assign target = (fu_data.op.bu == CF_JALR) ? ((a + fu_data.imm) & ~32'd1)
                                             : (fu_data.pc + fu_data.imm);

  assign bu_ready = !s1_valid_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= bu_valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clock) begin
    if (bu_valid) begin
      s1_tag_q <= fu_data.tag;
      s1_jump_q <= is_jump;
      s1_taken_q <= taken;
      s1_address_q <= taken ? target : next_pc;
      s1_next_pc_q <= next_pc;
    end
    if (s1_valid_q) begin
      s2_tag_q <= s1_tag_q;
      s2_link_q <= s1_jump_q ? s1_next_pc_q : 32'd0;
      branch_taken <= s1_taken_q;
      branch_address <= s1_address_q;
    end
  end

  assign wb_bu = '{valid: s2_valid_q, tag: s2_tag_q, data: s2_link_q};

endmodule

`default_nettype wire

// File: hw/issue.sv
`timescale 1ns/1ps
`default_nettype none

module issue
  import ooo_pkg::*;
(
  input  logic                clock,
  input  logic                arst_n,
  input  decoder_t            instr,
  input  logic                instr_valid,
  output logic                instr_ready,
  input  forwarding_t         fwd,
  input  logic                sb_full,
  input  reg_pending_t [31:0] rd_pending,
  input  sb_tag_t             issue_tag,
  output logic                issue_valid,
  output decoder_t            issue_instr,
  output fu_data_t            fu_data,
  output logic                alu_valid,
  output logic                bu_valid,
  input  logic                bu_ready,
  input  logic                gpr_we,
  input  logic [4:0]          gpr_waddr,
  input  logic [31:0]         gpr_wdata
);

  logic [31:0]      gpr_q [1:31];
  logic [1:0][4:0]  rs_addr;
  logic [1:0][31:0] rs_value;
  logic [1:0]       rs_ok;
  logic             operands_ok;
  logic             unit_ready;
  logic             out_of_reset_q;

  assign rs_addr[0] = instr.rs1;
  assign rs_addr[1] = instr.rs2;

  // Register file, or the result of the newest finished writer.
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rs_value[i] = '0;
      rs_ok[i] = 1'b1;
      if (rs_addr[i] != 5'd0) begin
        if (rd_pending[rs_addr[i]].pending) begin
          rs_ok[i] = fwd.finished[rd_pending[rs_addr[i]].tag];
          rs_value[i] = fwd.result[rd_pending[rs_addr[i]].tag];
        end else begin
          rs_value[i] = gpr_q[rs_addr[i]];
        end
      end
    end
  end

  assign operands_ok = rs_ok[0] && (instr.use_imm || rs_ok[1]);
  assign unit_ready = (instr.fu == FU_BU) ? bu_ready : 1'b1;

  assign instr_ready = out_of_reset_q && !sb_full && operands_ok && unit_ready;
  assign issue_valid = instr_valid && instr_ready;
  assign issue_instr = instr;

  always_ff @(posedge clock) begin
    if (gpr_we && gpr_waddr != 5'd0) begin
      gpr_q[gpr_waddr] <= gpr_wdata;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      out_of_reset_q <= 1'b0;
      alu_valid <= 1'b0;
      bu_valid <= 1'b0;
    end else begin
      out_of_reset_q <= 1'b1;
      alu_valid <= issue_valid && instr.fu == FU_ALU;
      bu_valid <= issue_valid && instr.fu == FU_BU;
    end
  end

  // The immediate replaces rs2 here, so the ALU sees one second operand.
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      fu_data.tag <= issue_tag;
      fu_data.op <= instr.op;
      fu_data.operand_a <= rs_value[0];
      fu_data.operand_b <= instr.use_imm ? instr.imm : rs_value[1];
      fu_data.imm <= instr.imm;
      fu_data.pc <= instr.pc;
      fu_data.is_rv16 <= instr.is_rv16;
    end
  end

endmodule

`default_nettype wire

// File: hw/scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard
  import ooo_pkg::*;
#(
  parameter int unsigned nr_entries = NrSbEntries
) (
  input  logic                             clock,
  input  logic                             arst_n,
  input  logic                             issue_valid,
  input  decoder_t                         issue_instr,
  output sb_tag_t                          issue_tag,
  output logic                             sb_full,
  output reg_pending_t [31:0]              rd_pending,
  input  writeback_t [WriteBackPorts-1:0]  wb,
  output forwarding_t                      fwd,
  output logic                             commit_valid,
  output decoder_t                         commit_instr,
  output logic [31:0]                      commit_data,
  input  logic                             commit_ack
);

  localparam int unsigned ptr_width = $clog2(nr_entries);

  logic [ptr_width-1:0] head_q;
  logic [ptr_width-1:0] tail_q;
  logic [ptr_width:0]   count_q;
  logic [nr_entries-1:0] finished_q;
  decoder_t             instr_q [nr_entries];
  logic [31:0]          result_q [nr_entries];
  reg_pending_t [31:0]  pending_q;

  assign issue_tag = sb_tag_t'(tail_q);
  assign sb_full = (count_q == (ptr_width + 1)'(nr_entries));
  assign rd_pending = pending_q;

  assign commit_valid = (count_q != '0) && finished_q[head_q];
  assign commit_instr = instr_q[head_q];
  assign commit_data = result_q[head_q];

  always_comb begin
    fwd = '0;
    for (int i = 0; i < nr_entries; i++) begin
      fwd.finished[i] = finished_q[i];
      fwd.result[i] = result_q[i];
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
      finished_q <= '0;
      pending_q <= '0;
    end else begin
      case ({issue_valid, commit_ack})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (commit_ack) begin
        head_q <= head_q + 1'b1;
        // Only the newest writer releases its register.
        if (pending_q[commit_instr.rd].tag == sb_tag_t'(head_q)) begin
          pending_q[commit_instr.rd].pending <= 1'b0;
        end
      end
      for (int p = 0; p < WriteBackPorts; p++) begin
        if (wb[p].valid) begin
          finished_q[wb[p].tag] <= 1'b1;
        end
      end
      if (issue_valid) begin
        tail_q <= tail_q + 1'b1;
        // An instruction without a unit is done as soon as it enters.
        finished_q[tail_q] <= (issue_instr.fu == FU_NONE);
        if (issue_instr.rd != 5'd0) begin
          pending_q[issue_instr.rd].pending <= 1'b1;
          pending_q[issue_instr.rd].tag <= issue_tag;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int p = 0; p < WriteBackPorts; p++) begin
      if (wb[p].valid) begin
        result_q[wb[p].tag] <= wb[p].data;
      end
    end
    if (issue_valid) begin
      instr_q[tail_q] <= issue_instr;
      result_q[tail_q] <= '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/commit.sv
`timescale 1ns/1ps
`default_nettype none

module commit
  import ooo_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  logic        commit_valid,
  input  decoder_t    commit_instr,
  input  logic [31:0] commit_data,
  output logic        commit_ack,
  output logic        gpr_we,
  output logic [4:0]  gpr_waddr,
  output logic [31:0] gpr_wdata,
  input  logic        branch_taken_q,
  input  logic [31:0] branch_address_q,
  output retire_t     retire,
  output logic        retire_valid
);

  logic        is_branch;
  logic [31:0] next_pc;

  // Retire is never stalled, so a finished head always leaves.
  assign commit_ack = commit_valid;

  assign gpr_we = commit_valid && commit_instr.rd != 5'd0;
  assign gpr_waddr = commit_instr.rd;
  assign gpr_wdata = commit_data;

  assign is_branch = (commit_instr.fu == FU_BU);
  assign next_pc = commit_instr.pc + (commit_instr.is_rv16 ? 32'd2 : 32'd4);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= commit_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (commit_valid) begin
      retire.pc <= commit_instr.pc;
      retire.rd <= commit_instr.rd;
      retire.data <= commit_data;
      retire.is_branch <= is_branch;
      retire.taken <= is_branch && branch_taken_q;
      retire.dnpc <= is_branch ? branch_address_q : next_pc;
    end
  end

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage
  import ooo_pkg::*;
#(
  parameter int unsigned nr_entries = NrSbEntries
) (
  input  logic                            clock,
  input  logic                            arst_n,
  input  decoder_t                        instr,
  input  logic                            instr_valid,
  output logic                            instr_ready,
  output fu_data_t                        fu_data,
  output logic                            alu_valid,
  output logic                            bu_valid,
  input  logic                            bu_ready,
  input  writeback_t [WriteBackPorts-1:0] wb,
  input  logic                            branch_taken,
  input  logic [31:0]                     branch_address,
  output retire_t                         retire,
  output logic                            retire_valid
);

  forwarding_t         fwd;
  reg_pending_t [31:0] rd_pending;
  logic                sb_full;
  sb_tag_t             issue_tag;
  logic                issue_valid;
  decoder_t            issue_instr;
  logic                commit_valid;
  decoder_t            commit_instr;
  logic [31:0]         commit_data;
  logic                commit_ack;
  logic                gpr_we;
  logic [4:0]          gpr_waddr;
  logic [31:0]         gpr_wdata;
  logic                branch_taken_q;
  logic [31:0]         branch_address_q;

  // Port 0 carries the branch unit, whose outcome travels beside the result.
  always_ff @(posedge clock) begin
    if (wb[0].valid) begin
      branch_taken_q <= branch_taken;
      branch_address_q <= branch_address;
    end
  end

  issue issue_inst (
    .clock      (clock),
    .arst_n     (arst_n),
    .instr      (instr),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .fwd        (fwd),
    .sb_full    (sb_full),
    .rd_pending (rd_pending),
    .issue_tag  (issue_tag),
    .issue_valid(issue_valid),
    .issue_instr(issue_instr),
    .fu_data    (fu_data),
    .alu_valid  (alu_valid),
    .bu_valid   (bu_valid),
    .bu_ready   (bu_ready),
    .gpr_we     (gpr_we),
    .gpr_waddr  (gpr_waddr),
    .gpr_wdata  (gpr_wdata)
  );

  scoreboard #(
    .nr_entries(nr_entries)
  ) scoreboard_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_instr (issue_instr),
    .issue_tag   (issue_tag),
    .sb_full     (sb_full),
    .rd_pending  (rd_pending),
    .wb          (wb),
    .fwd         (fwd),
    .commit_valid(commit_valid),
    .commit_instr(commit_instr),
    .commit_data (commit_data),
    .commit_ack  (commit_ack)
  );

  commit commit_inst (
    .clock           (clock),
    .arst_n          (arst_n),
    .commit_valid    (commit_valid),
    .commit_instr    (commit_instr),
    .commit_data     (commit_data),
    .commit_ack      (commit_ack),
    .gpr_we          (gpr_we),
    .gpr_waddr       (gpr_waddr),
    .gpr_wdata       (gpr_wdata),
    .branch_taken_q  (branch_taken_q),
    .branch_address_q(branch_address_q),
    .retire          (retire),
    .retire_valid    (retire_valid)
  );

endmodule

`default_nettype wire

// File: hw/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core
  import ooo_pkg::*;
#(
  parameter int unsigned nr_entries = NrSbEntries
) (
  input  logic     clock,
  input  logic     arst_n,
  input  decoder_t instr,
  input  logic     instr_valid,
  output logic     instr_ready,
  output retire_t  retire,
  output logic     retire_valid
);

  fu_data_t                        fu_data;
  logic                            alu_valid;
  logic                            bu_valid;
  logic                            bu_ready;
  writeback_t [WriteBackPorts-1:0] wb;
  logic                            branch_taken;
  logic [31:0]                     branch_address;

  issue_stage #(
    .nr_entries(nr_entries)
  ) issue_stage_inst (
    .clock         (clock),
    .arst_n        (arst_n),
    .instr         (instr),
    .instr_valid   (instr_valid),
    .instr_ready   (instr_ready),
    .fu_data       (fu_data),
    .alu_valid     (alu_valid),
    .bu_valid      (bu_valid),
    .bu_ready      (bu_ready),
    .wb            (wb),
    .branch_taken  (branch_taken),
    .branch_address(branch_address),
    .retire        (retire),
    .retire_valid  (retire_valid)
  );

  // Write-back port 0 is the branch unit, port 1 the ALU.
  branch_unit branch_unit_inst (
    .clock         (clock),
    .arst_n        (arst_n),
    .bu_valid      (bu_valid),
    .fu_data       (fu_data),
    .bu_ready      (bu_ready),
    .wb_bu         (wb[0]),
    .branch_taken  (branch_taken),
    .branch_address(branch_address)
  );

  alu_unit alu_unit_inst (
    .clock    (clock),
    .arst_n   (arst_n),
    .alu_valid(alu_valid),
    .fu_data  (fu_data),
    .wb_alu   (wb[1])
  );

endmodule

`default_nettype wire

// File: dv/tb_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core
  import ooo_pkg::*;
;

  localparam int unsigned half_period = 50;
  localparam int unsigned drive_delay = 10;
  localparam int unsigned reset_cycles = 8;

  logic     clock;
  logic     arst_n;
  decoder_t instr;
  logic     instr_valid;
  logic     instr_ready;
  retire_t  retire;
  logic     retire_valid;

  decoder_t    instr_table [$];
  retire_t     expected_table [$];
  int unsigned accepted;
  int unsigned retired;
  int unsigned full_cycles;
  int unsigned cycle_count;
  int unsigned cycle_limit;

  exec_core #(
    .nr_entries(NrSbEntries)
  ) exec_core_inst (
    .clock       (clock),
    .arst_n      (arst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .retire      (retire),
    .retire_valid(retire_valid)
  );

  always #(half_period) clock = ~clock;

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic stop_run(input string reason);
    $display("%s", reason);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] time %0t ns %s expected 0x%08h actual 0x%08h",
             $time, name, expected, actual);
    abort_run();
  endtask

  task automatic check_ready(input logic expected, input logic actual);
    if (actual !== expected) begin
      report_mismatch("instr_ready", {31'd0, expected}, {31'd0, actual});
    end
  endtask

  task automatic check_retire(input int unsigned idx, input retire_t expected,
                              input retire_t actual);
    string tag;
    tag = $sformatf("retire[%0d]", idx);
    if (actual.pc !== expected.pc) begin
      report_mismatch({tag, ".pc"}, expected.pc, actual.pc);
    end
    if (actual.rd !== expected.rd) begin
      report_mismatch({tag, ".rd"}, {27'd0, expected.rd}, {27'd0, actual.rd});
    end
    if (actual.data !== expected.data) begin
      report_mismatch({tag, ".data"}, expected.data, actual.data);
    end
    if (actual.is_branch !== expected.is_branch) begin
      report_mismatch({tag, ".is_branch"}, {31'd0, expected.is_branch},
                      {31'd0, actual.is_branch});
    end
    if (actual.taken !== expected.taken) begin
      report_mismatch({tag, ".taken"}, {31'd0, expected.taken}, {31'd0, actual.taken});
    end
    if (actual.dnpc !== expected.dnpc) begin
      report_mismatch({tag, ".dnpc"}, expected.dnpc, actual.dnpc);
    end
  endtask

  // The next pc of an ALU row follows from the instruction length.
  task automatic alu_entry(input logic [31:0] pc, input alu_op_e op, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm, input logic use_imm,
                           input logic is_rv16, input logic [31:0] data);
    decoder_t d;
    retire_t  r;
    d = '0;
    d.pc = pc;
    d.fu = FU_ALU;
    d.op.alu = op;
    d.rs1 = rs1;
    d.rs2 = rs2;
    d.rd = rd;
    d.imm = imm;
    d.use_imm = use_imm;
    d.is_rv16 = is_rv16;
    r = '0;
    r.pc = pc;
    r.rd = rd;
    r.data = data;
    r.dnpc = pc + (is_rv16 ? 32'd2 : 32'd4);
    instr_table.push_back(d);
    expected_table.push_back(r);
  endtask

  task automatic branch_entry(input logic [31:0] pc, input bu_op_e op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [31:0] imm, input logic is_rv16,
                              input logic taken, input logic [31:0] dnpc,
                              input logic [31:0] data);
    decoder_t d;
    retire_t  r;
    d = '0;
    d.pc = pc;
    d.fu = FU_BU;
    d.op.bu = op;
    d.rs1 = rs1;
    d.rs2 = rs2;
    d.rd = rd;
    d.imm = imm;
    d.is_rv16 = is_rv16;
    r.pc = pc;
    r.rd = rd;
    r.data = data;
    r.is_branch = 1'b1;
    r.taken = taken;
    r.dnpc = dnpc;
    instr_table.push_back(d);
    expected_table.push_back(r);
  endtask

  task automatic fill_table();
    alu_entry(32'h100, ALU_ADD, 1, 0, 0, 32'd5, 1'b1, 1'b0, 32'd5);
    alu_entry(32'h104, ALU_ADD, 2, 0, 0, 32'd12, 1'b1, 1'b0, 32'd12);
    alu_entry(32'h108, ALU_ADD, 3, 1, 2, 32'd0, 1'b0, 1'b0, 32'd17);
    alu_entry(32'h10c, ALU_SUB, 4, 3, 1, 32'd0, 1'b0, 1'b0, 32'd12);
    alu_entry(32'h110, ALU_XOR, 5, 3, 2, 32'd0, 1'b0, 1'b0, 32'd29);
    alu_entry(32'h114, ALU_OR, 6, 5, 0, 32'h40, 1'b1, 1'b1, 32'h5d);
    alu_entry(32'h116, ALU_SLL, 7, 6, 0, 32'd4, 1'b1, 1'b1, 32'h5d0);
    alu_entry(32'h118, ALU_SRL, 8, 7, 1, 32'd0, 1'b0, 1'b0, 32'h2e);
    alu_entry(32'h11c, ALU_SLT, 9, 4, 5, 32'd0, 1'b0, 1'b0, 32'd1);
    alu_entry(32'h120, ALU_ADD, 10, 0, 0, 32'hfffffffd, 1'b1, 1'b0, 32'hfffffffd);
    alu_entry(32'h124, ALU_SLT, 11, 1, 10, 32'd0, 1'b0, 1'b0, 32'd0);
    // Branch ahead of independent ALU work that writes back in the same cycle.
    branch_entry(32'h128, BR_EQ, 0, 4, 2, 32'h20, 1'b0, 1'b1, 32'h148, 32'd0);
    alu_entry(32'h12c, ALU_ADD, 12, 0, 0, 32'd100, 1'b1, 1'b0, 32'd100);
    alu_entry(32'h130, ALU_ADD, 13, 12, 0, 32'd1, 1'b1, 1'b0, 32'd101);
    branch_entry(32'h134, BR_NE, 0, 1, 1, 32'h40, 1'b0, 1'b0, 32'h138, 32'd0);
    branch_entry(32'h138, BR_LT, 0, 10, 1, 32'hfffffff8, 1'b0, 1'b1, 32'h130, 32'd0);
    branch_entry(32'h13c, BR_GEU, 0, 10, 1, 32'h10, 1'b0, 1'b1, 32'h14c, 32'd0);
    branch_entry(32'h140, BR_LTU, 0, 10, 1, 32'h10, 1'b0, 1'b0, 32'h144, 32'd0);
    branch_entry(32'h144, BR_GE, 0, 1, 10, 32'h8, 1'b0, 1'b1, 32'h14c, 32'd0);
    branch_entry(32'h148, CF_JAL, 14, 0, 0, 32'h100, 1'b0, 1'b1, 32'h248, 32'h14c);
    branch_entry(32'h14c, CF_JALR, 15, 14, 0, 32'h5, 1'b0, 1'b1, 32'h150, 32'h150);
    branch_entry(32'h150, CF_JAL, 16, 0, 0, 32'h10, 1'b1, 1'b1, 32'h160, 32'h152);
    alu_entry(32'h152, ALU_ADD, 17, 15, 16, 32'd0, 1'b0, 1'b0, 32'h2a2);
    // A slow branch and a burst behind it fill the scoreboard.
    branch_entry(32'h156, BR_EQ, 0, 1, 2, 32'h20, 1'b0, 1'b0, 32'h15a, 32'd0);
    alu_entry(32'h15a, ALU_ADD, 18, 0, 0, 32'd1, 1'b1, 1'b0, 32'd1);
    alu_entry(32'h15e, ALU_ADD, 19, 0, 0, 32'd2, 1'b1, 1'b0, 32'd2);
    alu_entry(32'h162, ALU_ADD, 20, 0, 0, 32'd3, 1'b1, 1'b0, 32'd3);
    alu_entry(32'h166, ALU_ADD, 21, 0, 0, 32'd4, 1'b1, 1'b0, 32'd4);
    alu_entry(32'h16a, ALU_ADD, 22, 18, 21, 32'd0, 1'b0, 1'b0, 32'd5);
    alu_entry(32'h16e, ALU_ADD, 22, 22, 19, 32'd0, 1'b0, 1'b0, 32'd7);
    alu_entry(32'h172, ALU_ADD, 22, 22, 20, 32'd0, 1'b0, 1'b0, 32'd10);
    alu_entry(32'h176, ALU_SLL, 23, 22, 19, 32'd0, 1'b0, 1'b0, 32'd40);
  endtask

  // Holds the instruction until instr_ready is seen before a rising edge.
  task automatic send_instr(input decoder_t d, input int unsigned max_wait);
    int unsigned waited;
    waited = 0;
    instr = d;
    instr_valid = 1'b1;
    @(negedge clock);
    while (instr_ready !== 1'b1) begin
      waited++;
      if (waited > max_wait) begin
        stop_run("Instruction was not accepted in time after reset");
      end
      @(negedge clock);
    end
    @(posedge clock);
    accepted++;
    #(drive_delay);
  endtask

  always @(negedge clock) begin
    if (retire_valid !== 1'b0) begin
      if (retired >= accepted) begin
        stop_run("retire_valid was high with no accepted instruction left to retire");
      end else begin
        check_retire(retired, expected_table[retired], retire);
        retired++;
      end
    end
    // A full scoreboard must hold back the waiting instruction.
    if (instr_valid === 1'b1 && (accepted - retired) == NrSbEntries) begin
      full_cycles++;
      check_ready(1'b0, instr_ready);
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      stop_run("Timeout: not every instruction retired within the cycle limit");
    end
  end

  initial begin
    clock = 1'b0;
    arst_n = 1'b0;
    instr = '0;
    instr_valid = 1'b0;
    accepted = 0;
    retired = 0;
    full_cycles = 0;
    cycle_count = 0;
    fill_table();
    cycle_limit = 8 * instr_table.size() + 50;
    repeat (reset_cycles) @(posedge clock);
    #(drive_delay);
    arst_n = 1'b1;
    @(negedge clock);
    check_ready(1'b0, instr_ready);
    @(posedge clock);
    #(drive_delay);
    for (int i = 0; i < instr_table.size(); i++) begin
      send_instr(instr_table[i], (i == 0) ? 4 : cycle_limit);
    end
    instr_valid = 1'b0;
    instr = '0;
    wait (retired == instr_table.size());
    // A few idle cycles catch any extra retire record.
    repeat (4) @(negedge clock);
    if (full_cycles == 0) begin
      stop_run("The scoreboard never filled while an instruction was waiting");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
hw/ooo_pkg.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/issue.sv
hw/scoreboard.sv
hw/commit.sv
hw/issue_stage.sv
hw/exec_core.sv
dv/tb_exec_core.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_exec_core -f sim.f \
  -o tb_exec_core > sim.log 2>&1 \
  && ./obj_dir/tb_exec_core >> sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1
